//--- build.f
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/line_xfer_if.sv
rtl/cache_lookup_ctrl.sv
rtl/mem_xfer_seq.sv
rtl/cache_controller.sv
dv/cache_controller_sva.sv
dv/cache_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the simulator from build.f, runs it and looks for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module cache_controller_tb -f build.f \
  -o cache_controller_sim > build.log 2>&1 \
  && ./obj_dir/cache_controller_sim > sim.log 2>&1 \
  || echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

//--- dv/cache_controller_tb.sv
`timescale 1ns/1ps

module cache_controller_tb
  import cache_pkg::*;
  import mem_pkg::*;
();

  localparam int num_rows = 10;
  localparam int timeout_cycles = num_rows * 40;
  localparam int op_read = 0;
  localparam int op_write = 1;
  localparam int op_both = 2;

  typedef struct {
    string       name;
    int          op;
    logic        hit;
    logic        valid;
    logic        dirty;
    cache_addr_t addr;
    cache_tag_t  victim_tag;
    int          busy_cycles;
    int          exp_xfers;
  } row_t;

  logic              clk;
  logic              reset;
  cache_addr_t       addr;
  logic              read;
  logic              write;
  logic              hit;
  logic              dirty;
  logic              valid;
  mem_busy_t         busy;
  cache_tag_t        cache_tag_in;
  logic              enable;
  logic              comp;
  logic              c_write;
  logic              valid_in;
  logic              mem_cache_wr;
  cache_offset_t     cache_offset;
  cache_tag_t        cache_tag_out;
  logic              mem_wr;
  logic              mem_rd;
  logic [addr_w-1:0] mem_address;
  logic              done;
  logic              stall_cache;

  row_t rows [num_rows];
  int   cyc = 0;

  cache_controller cache_controller_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == timeout_cycles) begin
      $display("timeout reached after %0d cycles with the table unfinished", cyc);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_addr(input string name, input cache_addr_t exp, input cache_addr_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp.word, act.word);
      abort_run();
    end
  endtask

  task automatic check_offset(input string name, input cache_offset_t exp,
                              input cache_offset_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic set_row(input int idx, input string name, input int op, input logic h,
                         input logic v, input logic d, input int busy_n, input int xfers);
    rows[idx].name = name;
    rows[idx].op = op;
    rows[idx].hit = h;
    rows[idx].valid = v;
    rows[idx].dirty = d;
    rows[idx].addr.word = 16'($urandom);
    // the victim always differs from the requested tag
    rows[idx].victim_tag = rows[idx].addr.fields.tag ^ cache_tag_t'($urandom_range(1, 31));
    rows[idx].busy_cycles = busy_n;
    rows[idx].exp_xfers = xfers;
  endtask

  task automatic fill_table();
    set_row(0, "read_hit", op_read, 1, 1, 0, 0, 0);
    set_row(1, "write_hit", op_write, 1, 1, 1, 0, 0);
    set_row(2, "read_miss_clean", op_read, 0, 1, 0, 0, 4);
    set_row(3, "read_miss_invalid", op_read, 0, 0, 1, 0, 4);
    set_row(4, "read_hit_invalid", op_read, 1, 0, 0, 0, 4);
    set_row(5, "read_miss_dirty", op_read, 0, 1, 1, 0, 8);
    set_row(6, "read_miss_busy", op_read, 0, 1, 1, 3, 8);
    set_row(7, "write_miss_clean", op_write, 0, 1, 0, 0, 4);
    set_row(8, "write_miss_busy", op_write, 0, 1, 1, 5, 8);
    set_row(9, "both_raised_hit", op_both, 1, 1, 0, 0, 0);
  endtask

  // edges from the request edge to the edge that samples done, zero where it varies
  function automatic int expected_latency(input int idx);
    if (rows[idx].hit && rows[idx].valid) begin
      return 2;
    end
    if (rows[idx].valid && rows[idx].dirty) begin
      return 0;
    end
    return (rows[idx].op == op_read) ? 9 : 10;
  endfunction

  task automatic verify_quiet_outputs(input string name);
    check_count({name, " control outputs"}, 0,
                int'({enable, comp, c_write, valid_in, mem_cache_wr, mem_wr, mem_rd, done,
                      stall_cache}));
    check_count({name, " offset tag address"}, 0,
                int'({cache_offset, cache_tag_out, mem_address}));
  endtask

  task automatic run_row(input int idx);
    row_t          r;
    int            req_edge;
    int            busy_left;
    int            busy_zero_cyc;
    int            exp_lat;
    logic          is_write;
    logic          line_miss;
    logic          wb_needed;
    logic          finished;
    logic          prev_c_write;
    logic          prev_valid_in;
    logic          prev_mem_cache_wr;
    cache_addr_t   seen;
    cache_addr_t   exp_a;
    cache_offset_t exp_o;
    cache_addr_t   wr_q [$];
    cache_addr_t   rd_q [$];
    int            rd_cyc_q [$];
    cache_offset_t fill_q [$];
    int            fill_cyc_q [$];
    r = rows[idx];
    is_write = (r.op != op_read);
    line_miss = !(r.hit && r.valid);
    wb_needed = line_miss && r.valid && r.dirty;
    busy_left = 0;
    busy_zero_cyc = -1;
    finished = 1'b0;
    prev_c_write = 1'b0;
    prev_valid_in = 1'b0;
    prev_mem_cache_wr = 1'b0;
    @(posedge clk);
    #1;
    addr = r.addr;
    read = (r.op != op_write);
    write = (r.op != op_read);
    hit = r.hit;
    valid = r.valid;
    dirty = r.dirty;
    cache_tag_in = r.victim_tag;
    busy = '0;
    req_edge = cyc + 1;
    while (!finished) begin
      @(posedge clk);
      #1;
      if (busy_left > 0) begin
        busy = mem_busy_t'($urandom_range(1, 15));
        busy_left--;
      end else if (busy != '0) begin
        busy = '0;
        busy_zero_cyc = cyc;
      end
      // outputs are sampled mid-cycle, well away from both clock edges
      @(negedge clk);
      if (cyc == req_edge) begin
        check_count({r.name, " compare enable"}, 1, int'(enable && comp));
        check_count({r.name, " compare c_write"}, int'(is_write), int'(c_write));
      end
      if (mem_wr) begin
        seen.word = mem_address;
        wr_q.push_back(seen);
        if (wr_q.size() == words_per_line) begin
          busy_left = r.busy_cycles;
        end
      end
      if (mem_rd) begin
        seen.word = mem_address;
        rd_q.push_back(seen);
        rd_cyc_q.push_back(cyc);
      end
      if (mem_cache_wr) begin
        check_count({r.name, " fill write strobes"}, 1, int'(c_write && valid_in));
        check_count({r.name, " fill tag"}, int'(r.addr.fields.tag), int'(cache_tag_out));
        fill_q.push_back(cache_offset);
        fill_cyc_q.push_back(cyc);
      end
      if (done) begin
        finished = 1'b1;
      end else begin
        check_count({r.name, " stall before done"}, 1, int'(stall_cache));
        prev_c_write = c_write;
        prev_valid_in = valid_in;
        prev_mem_cache_wr = mem_cache_wr;
      end
    end
    check_count({r.name, " transfers"}, r.exp_xfers, wr_q.size() + rd_q.size());
    check_count({r.name, " write-back beats"}, wb_needed ? words_per_line : 0, wr_q.size());
    check_count({r.name, " fill reads"}, line_miss ? words_per_line : 0, rd_q.size());
    check_count({r.name, " fill writes"}, line_miss ? words_per_line : 0, fill_q.size());
    foreach (wr_q[i]) begin
      exp_a.fields.tag = r.victim_tag;
      exp_a.fields.index = r.addr.fields.index;
      exp_a.fields.offset.word_idx = word_idx_t'(i);
      exp_a.fields.offset.byte_sel = r.addr.fields.offset.byte_sel;
      check_addr($sformatf("%s write-back word %0d", r.name, i), exp_a, wr_q[i]);
    end
    foreach (rd_q[i]) begin
      exp_a.fields.tag = r.addr.fields.tag;
      exp_a.fields.index = r.addr.fields.index;
      exp_a.fields.offset.word_idx = word_idx_t'(i);
      exp_a.fields.offset.byte_sel = r.addr.fields.offset.byte_sel;
      check_addr($sformatf("%s fill read word %0d", r.name, i), exp_a, rd_q[i]);
      exp_o.word_idx = word_idx_t'(i);
      exp_o.byte_sel = r.addr.fields.offset.byte_sel;
      check_offset($sformatf("%s fill offset %0d", r.name, i), exp_o, fill_q[i]);
      check_count($sformatf("%s fill delay %0d", r.name, i), mem_read_latency,
                  fill_cyc_q[i] - rd_cyc_q[i]);
    end
    if (r.busy_cycles > 0 && (busy_zero_cyc < 0 || rd_cyc_q[0] < busy_zero_cyc)) begin
      $display("%s: the fill started while the memory banks were still busy", r.name);
      abort_run();
    end
    exp_lat = expected_latency(idx);
    if (exp_lat > 0) begin
      check_count({r.name, " done latency"}, exp_lat, cyc + 1 - req_edge);
    end
    if (is_write && line_miss) begin
      check_count({r.name, " allocate write"}, 2'b10,
                  int'({prev_c_write && prev_valid_in, prev_mem_cache_wr}));
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    addr = '0;
    read = 1'b0;
    write = 1'b0;
    hit = 1'b0;
    dirty = 1'b0;
    valid = 1'b0;
    busy = '0;
    cache_tag_in = '0;
    void'($urandom(24412));
    fill_table();
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (3) begin
      @(negedge clk);
      verify_quiet_outputs("after_reset");
    end
    // rows run back to back, each new request starting right after done
    for (int i = 0; i < num_rows; i++) begin
      run_row(i);
    end
    @(posedge clk);
    #1;
    read = 1'b0;
    write = 1'b0;
    $display("All checks passed");
    $finish;
  end

endmodule

//--- dv/cache_controller_sva.sv
`timescale 1ns/1ps

module cache_controller_sva (
  input logic clk,
  input logic reset,
  input logic done,
  input logic stall_cache,
  input logic mem_wr,
  input logic mem_rd
);

  // the cycle that completes a request no longer stalls the cache
  done_not_stalled: assert property (
    @(posedge clk) disable iff (reset) !(done && stall_cache)
  ) else $error("done and stall_cache high in the same cycle");

  // the memory port carries one burst beat at a time
  one_memory_op: assert property (
    @(posedge clk) disable iff (reset) !(mem_wr && mem_rd)
  ) else $error("mem_wr and mem_rd high in the same cycle");

  done_single_cycle: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  ) else $error("done stayed high for more than one cycle");

endmodule

bind cache_controller cache_controller_sva cache_controller_sva_i (
  .clk         (clk),
  .reset       (reset),
  .done        (done),
  .stall_cache (stall_cache),
  .mem_wr      (mem_wr),
  .mem_rd      (mem_rd)
);

//--- rtl/cache_controller.sv
`timescale 1ns/1ps

module cache_controller
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  cache_addr_t       addr,
  input  logic              read,
  input  logic              write,
  input  logic              hit,
  input  logic              dirty,
  input  logic              valid,
  input  mem_busy_t         busy,
  input  cache_tag_t        cache_tag_in,
  output logic              enable,
  output logic              comp,
  output logic              c_write,
  output logic              valid_in,
  output logic              mem_cache_wr,
  output cache_offset_t     cache_offset,
  output cache_tag_t        cache_tag_out,
  output logic              mem_wr,
  output logic              mem_rd,
  output logic [addr_w-1:0] mem_address,
  output logic              done,
  output logic              stall_cache
);

  line_xfer_if xfer ();

  // request handshake, tag compare and cache-side writes
  cache_lookup_ctrl cache_lookup_ctrl_i (
    .clk           (clk),
    .reset         (reset),
    .addr          (addr),
    .read          (read),
    .write         (write),
    .hit           (hit),
    .dirty         (dirty),
    .valid         (valid),
    .cache_tag_in  (cache_tag_in),
    .xfer          (xfer.lookup),
    .enable        (enable),
    .comp          (comp),
    .c_write       (c_write),
    .valid_in      (valid_in),
    .mem_cache_wr  (mem_cache_wr),
    .cache_offset  (cache_offset),
    .cache_tag_out (cache_tag_out),
    .done          (done),
    .stall_cache   (stall_cache)
  );

  // write-back and fill bursts toward memory
  mem_xfer_seq mem_xfer_seq_i (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .busy        (busy),
    .xfer        (xfer.seq),
    .mem_wr      (mem_wr),
    .mem_rd      (mem_rd),
    .mem_address (mem_address)
  );

endmodule

//--- rtl/mem_xfer_seq.sv
`timescale 1ns/1ps

module mem_xfer_seq
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  cache_addr_t       addr,
  input  mem_busy_t         busy,
  line_xfer_if.seq          xfer,
  output logic              mem_wr,
  output logic              mem_rd,
  output logic [addr_w-1:0] mem_address
);

  logic [seq_state_w-1:0]      state_q;
  logic [seq_state_w-1:0]      state_d;
  word_idx_t                   beat_q;
  cache_tag_t                  wb_tag_q;
  logic                        accept;
  logic                        last_beat;
  logic                        last_fill;
  cache_addr_t                 beat_addr;
  logic [mem_read_latency-1:0] rd_pipe_q;
  word_idx_t                   word_pipe_q [mem_read_latency];

  // the first beat goes out in the same cycle the request is taken
  assign accept = (state_q == seq_idle) && xfer.xfer_req;
  assign last_beat = (beat_q == last_word);
  assign last_fill = xfer.fill_valid && (xfer.fill_word == last_word);

  assign mem_wr = (accept && xfer.xfer_writeback) || (state_q == seq_wb);
  assign mem_rd = (accept && !xfer.xfer_writeback) || (state_q == seq_fill);

  always_comb begin
    if (state_q == seq_wb) begin
      beat_addr.fields.tag = wb_tag_q;
    end else if (accept && xfer.xfer_writeback) begin
      beat_addr.fields.tag = xfer.victim_tag;
    end else begin
      beat_addr.fields.tag = addr.fields.tag;
    end
    beat_addr.fields.index = addr.fields.index;
    beat_addr.fields.offset.word_idx = beat_q;
    beat_addr.fields.offset.byte_sel = addr.fields.offset.byte_sel;
  end

  assign mem_address = (mem_wr || mem_rd) ? beat_addr.word : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      seq_idle: begin
        if (xfer.xfer_req) begin
          state_d = xfer.xfer_writeback ? seq_wb : seq_fill;
        end
      end
      seq_wb: begin
        if (last_beat) begin
          state_d = seq_bank;
        end
      end
      // banks are only checked after a write-back
      seq_bank: begin
        if (busy == '0) begin
          state_d = seq_fill;
        end
      end
      seq_fill: begin
        if (last_beat) begin
          state_d = seq_drain;
        end
      end
      seq_drain: begin
        if (last_fill) begin
          state_d = seq_done;
        end
      end
      seq_done: begin
        state_d = seq_idle;
      end
      default: begin
        state_d = seq_idle;
      end
    endcase
  end

  // beat counter wraps back to word 0 after each burst
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= seq_idle;
      beat_q <= '0;
    end else begin
      state_q <= state_d;
      if (mem_wr || mem_rd) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_tag_q <= xfer.victim_tag;
    end
  end

  // read latency model, one stage per cycle of memory delay
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pipe_q <= '0;
    end else begin
      rd_pipe_q[0] <= mem_rd;
      for (int i = 1; i < mem_read_latency; i++) begin
        rd_pipe_q[i] <= rd_pipe_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    word_pipe_q[0] <= beat_q;
    for (int i = 1; i < mem_read_latency; i++) begin
      word_pipe_q[i] <= word_pipe_q[i-1];
    end
  end

  assign xfer.fill_valid = rd_pipe_q[mem_read_latency-1];
  assign xfer.fill_word = word_pipe_q[mem_read_latency-1];
  assign xfer.xfer_done = (state_q == seq_done);

endmodule

//--- rtl/cache_lookup_ctrl.sv
`timescale 1ns/1ps

module cache_lookup_ctrl
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  cache_addr_t        addr,
  input  logic               read,
  input  logic               write,
  input  logic               hit,
  input  logic               dirty,
  input  logic               valid,
  input  cache_tag_t         cache_tag_in,
  line_xfer_if.lookup        xfer,
  output logic               enable,
  output logic               comp,
  output logic               c_write,
  output logic               valid_in,
  output logic               mem_cache_wr,
  output cache_offset_t      cache_offset,
  output cache_tag_t         cache_tag_out,
  output logic               done,
  output logic               stall_cache
);

  logic [lookup_state_w-1:0] state_q;
  logic [lookup_state_w-1:0] state_d;
  logic                      is_write_q;
  logic                      writeback_q;
  cache_tag_t                victim_tag_q;
  logic                      line_hit;

  assign line_hit = hit && valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= lk_idle;
      is_write_q <= 1'b0;
      writeback_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // write wins when both are raised together
      if (state_q == lk_idle && (read || write)) begin
        is_write_q <= write;
      end
      if (state_q == lk_comp) begin
        writeback_q <= valid && dirty && !hit;
      end
    end
  end

  // the victim tag is only meaningful when writeback_q is set
  always_ff @(posedge clk) begin
    if (state_q == lk_comp) begin
      victim_tag_q <= cache_tag_in;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      lk_idle: begin
        if (read || write) begin
          state_d = lk_comp;
        end
      end
      lk_comp: begin
        state_d = line_hit ? lk_done : lk_xfer;
      end
      lk_xfer: begin
        if (xfer.xfer_done) begin
          state_d = is_write_q ? lk_cache_wr : lk_done;
        end
      end
      lk_cache_wr: begin
        state_d = lk_done;
      end
      lk_done: begin
        state_d = lk_idle;
      end
      default: begin
        state_d = lk_idle;
      end
    endcase
  end

  always_comb begin
    enable = 1'b0;
    comp = 1'b0;
    c_write = 1'b0;
    valid_in = 1'b0;
    mem_cache_wr = 1'b0;
    done = 1'b0;
    stall_cache = 1'b0;
    cache_offset = '0;
    cache_tag_out = '0;
    if (state_q != lk_idle) begin
      cache_tag_out = addr.fields.tag;
      cache_offset = addr.fields.offset;
    end
    case (state_q)
      lk_comp: begin
        enable = 1'b1;
        comp = 1'b1;
        c_write = is_write_q;
        stall_cache = 1'b1;
      end
      lk_xfer: begin
        enable = 1'b1;
        stall_cache = 1'b1;
        // fill words land in the line while the sequencer streams them in
        if (xfer.fill_valid) begin
          c_write = 1'b1;
          valid_in = 1'b1;
          mem_cache_wr = 1'b1;
          cache_offset.word_idx = xfer.fill_word;
        end
      end
      lk_cache_wr: begin
        enable = 1'b1;
        c_write = 1'b1;
        valid_in = 1'b1;
        stall_cache = 1'b1;
      end
      lk_done: begin
        enable = 1'b1;
        done = 1'b1;
      end
      default: begin
        enable = 1'b0;
      end
    endcase
  end

  assign xfer.xfer_req = (state_q == lk_xfer);
  assign xfer.xfer_writeback = writeback_q;
  assign xfer.victim_tag = victim_tag_q;

endmodule

//--- rtl/line_xfer_if.sv
`timescale 1ns/1ps

interface line_xfer_if
  import cache_pkg::*;
();

  // request side, owned by the lookup controller
  logic       xfer_req;
  logic       xfer_writeback;
  cache_tag_t victim_tag;

  // completion and fill data, owned by the memory sequencer
  logic       xfer_done;
  logic       fill_valid;
  word_idx_t  fill_word;

  modport lookup (
    output xfer_req,
    output xfer_writeback,
    output victim_tag,
    input  xfer_done,
    input  fill_valid,
    input  fill_word
  );

  modport seq (
    input  xfer_req,
    input  xfer_writeback,
    input  victim_tag,
    output xfer_done,
    output fill_valid,
    output fill_word
  );

endinterface

//--- rtl/mem_pkg.sv
package mem_pkg;

  // one busy bit per memory bank
  localparam int mem_banks = 4;

  typedef logic [mem_banks-1:0] mem_busy_t;

  // cycles from mem_rd until the word can be written into the cache
  localparam int mem_read_latency = 2;

  // sequencer state encoding
  localparam int seq_state_w = 3;
  localparam logic [seq_state_w-1:0] seq_idle = 3'd0;
  localparam logic [seq_state_w-1:0] seq_wb = 3'd1;
  localparam logic [seq_state_w-1:0] seq_bank = 3'd2;
  localparam logic [seq_state_w-1:0] seq_fill = 3'd3;
  localparam logic [seq_state_w-1:0] seq_drain = 3'd4;
  localparam logic [seq_state_w-1:0] seq_done = 3'd5;

endpackage

//--- rtl/cache_pkg.sv
package cache_pkg;

  // 16-bit byte address split as tag | index | word | byte
  localparam int tag_w = 5;
  localparam int index_w = 8;
  localparam int offset_w = 3;
  localparam int addr_w = 16;
  localparam int words_per_line = 4;

  typedef logic [tag_w-1:0] cache_tag_t;
  typedef logic [index_w-1:0] cache_index_t;
  typedef logic [offset_w-2:0] word_idx_t;

  typedef struct packed {
    word_idx_t word_idx;
    logic      byte_sel;
  } cache_offset_t;

  // flat memory word on one side, decoded address fields on the other
  typedef union packed {
    logic [addr_w-1:0] word;
    struct packed {
      cache_tag_t    tag;
      cache_index_t  index;
      cache_offset_t offset;
    } fields;
  } cache_addr_t;

  localparam word_idx_t last_word = word_idx_t'(words_per_line - 1);

  // lookup controller state encoding
  localparam int lookup_state_w = 3;
  localparam logic [lookup_state_w-1:0] lk_idle = 3'd0;
  localparam logic [lookup_state_w-1:0] lk_comp = 3'd1;
  localparam logic [lookup_state_w-1:0] lk_xfer = 3'd2;
  localparam logic [lookup_state_w-1:0] lk_cache_wr = 3'd3;
  localparam logic [lookup_state_w-1:0] lk_done = 3'd4;

endpackage
